// ==== project.f ====
source/cache_pkg.sv
source/cache_ctrl.sv
source/lru_ages.sv
source/cache_ways.sv
source/cache_top.sv
tests/tb_cache.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_cache
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/tb_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache
	import cache_pkg::*;
();

	logic   clk;
	logic   reset_i;
	logic   cpu_req_i;
	logic   cpu_we_i;
	addr_t  cpu_addr_i;
	byte_t  cpu_wdata_i;
	logic   cpu_ready_o;
	byte_t  cpu_rdata_o;
	logic   mem_valid_o;
	logic   mem_we_o;
	addr_t  mem_addr_o;
	block_t mem_wdata_o;
	logic   mem_ready_i;
	block_t mem_rdata_i;

	block_t mem_blocks [addr_t]; // backing memory, only blocks written back
	byte_t  written    [addr_t]; // latest byte the core wrote, per byte address
	bit     dirty_blk  [addr_t]; // resident blocks holding written bytes
	tag_t   rec_tags   [SETS][WAYS]; // entry 0 is the most recent tag
	int     rec_count  [SETS];
	int     writebacks;

	cache_top i_dut (
		.clk         (clk),
		.reset_i     (reset_i),
		.cpu_req_i   (cpu_req_i),
		.cpu_we_i    (cpu_we_i),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_wdata_i (cpu_wdata_i),
		.cpu_ready_o (cpu_ready_o),
		.cpu_rdata_o (cpu_rdata_o),
		.mem_valid_o (mem_valid_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_ready_i (mem_ready_i),
		.mem_rdata_i (mem_rdata_i)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED: %s expected %h actual %h", name, expected, actual);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic stop_with_error(input string what);
		$display("ERROR: %s", what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// untouched memory, mixes every address bit into the byte
	function automatic byte_t pattern_byte(addr_t a);
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
	endfunction

	function automatic byte_t model_byte(addr_t a);
		if (written.exists(a)) begin
			return written[a];
		end
		return pattern_byte(a);
	endfunction

	function automatic block_t model_block(addr_t base);
		block_t b;
		for (int k = 0; k < BLOCK_BYTES; k++) begin
			b[8*k +: 8] = model_byte(base + addr_t'(k));
		end
		return b;
	endfunction

	function automatic block_t memory_read(addr_t base);
		block_t b;
		if (mem_blocks.exists(base)) begin
			return mem_blocks[base];
		end
		for (int k = 0; k < BLOCK_BYTES; k++) begin
			b[8*k +: 8] = pattern_byte(base + addr_t'(k));
		end
		return b;
	endfunction

	function automatic addr_t make_addr(int tag_idx, int set_idx, int offset);
		return {tag_t'(tag_idx) + 25'h0a5c30, set_t'(set_idx), offset_t'(offset)};
	endfunction

	// recency list per set, the last of four full entries is the victim
	task automatic model_access(input logic we, input addr_t addr, input byte_t wdata,
			output logic wb, output addr_t wb_addr, output logic rd);
		set_t  s;
		tag_t  t;
		addr_t victim;
		int    pos;
		s       = addr[6:4];
		t       = addr[31:7];
		pos     = -1;
		wb      = 1'b0;
		wb_addr = '0;
		for (int i = 0; i < rec_count[s]; i++) begin
			if (rec_tags[s][i] == t) begin
				pos = i;
			end
		end
		rd = (pos < 0);
		if (pos < 0 && rec_count[s] == WAYS) begin
			victim  = {rec_tags[s][WAYS-1], s, 4'h0};
			wb      = dirty_blk.exists(victim);
			wb_addr = victim;
			dirty_blk.delete(victim);
			pos = WAYS - 1;
		end else if (pos < 0) begin
			pos = rec_count[s];
			rec_count[s]++;
		end
		for (int i = pos; i > 0; i--) begin
			rec_tags[s][i] = rec_tags[s][i-1]; // more recent tags move down one
		end
		rec_tags[s][0] = t;
		if (we) begin
			written[addr] = wdata;
			dirty_blk[{t, s, 4'h0}] = 1'b1;
		end
	endtask

	task automatic cpu_access(input logic we, input addr_t addr, input byte_t wdata);
		logic  wb;
		addr_t wb_addr;
		logic  rd;
		byte_t expected;
		int    waited;
		int    delay;
		logic  done;
		expected = model_byte(addr);
		model_access(we, addr, wdata, wb, wb_addr, rd);
		@(posedge clk);
		#1;
		cpu_req_i   = 1'b1;
		cpu_we_i    = we;
		cpu_addr_i  = addr;
		cpu_wdata_i = wdata;
		waited      = 0;
		done        = 1'b0;
		while (!done) begin
			@(negedge clk);
			if (cpu_ready_o) begin
				if (wb || rd) begin
					stop_with_error("cpu_ready_o rose before the expected memory transfer");
				end
				if (!we) begin
					check("cpu_rdata_o", 128'(expected), 128'(cpu_rdata_o));
				end
				done = 1'b1;
			end else if (mem_valid_o) begin
				if (wb) begin
					check("mem_we_o", 128'(1'b1), 128'(mem_we_o));
					check("mem_addr_o", 128'(wb_addr), 128'(mem_addr_o));
					check("mem_wdata_o", model_block(wb_addr), mem_wdata_o);
					mem_blocks[wb_addr] = mem_wdata_o;
					wb = 1'b0;
					writebacks++;
				end else if (rd) begin
					check("mem_we_o", 128'(1'b0), 128'(mem_we_o));
					check("mem_addr_o", 128'({addr[31:4], 4'h0}), 128'(mem_addr_o));
					rd = 1'b0;
				end else begin
					stop_with_error("memory request seen where the model expects none");
				end
				delay = $urandom_range(0, 5);
				repeat (delay) @(posedge clk);
				@(posedge clk);
				#1;
				mem_ready_i = 1'b1;
				mem_rdata_i = memory_read({addr[31:4], 4'h0});
				@(posedge clk);
				#1;
				mem_ready_i = 1'b0;
				waited = 0;
			end else begin
				waited++;
				if (waited >= 200) begin
					stop_with_error("timed out waiting for cpu_ready_o or mem_valid_o");
				end
			end
		end
		@(posedge clk);
		#1;
		cpu_req_i = 1'b0;
	endtask

	initial begin
		void'($urandom(32'he208));
		reset_i     = 1'b1;
		cpu_req_i   = 1'b0;
		cpu_we_i    = 1'b0;
		cpu_addr_i  = '0;
		cpu_wdata_i = '0;
		mem_ready_i = 1'b0;
		mem_rdata_i = '0;
		writebacks  = 0;
		for (int s = 0; s < SETS; s++) begin
			rec_count[s] = 0;
		end

		// outputs stay quiet through reset and just after release
		for (int i = 0; i < 13; i++) begin
			if (i == 10) begin
				@(posedge clk);
				#1;
				reset_i = 1'b0;
			end
			@(negedge clk);
			check("cpu_ready_o", 128'(1'b0), 128'(cpu_ready_o));
			check("mem_valid_o", 128'(1'b0), 128'(mem_valid_o));
			check("mem_we_o", 128'(1'b0), 128'(mem_we_o));
		end

		cpu_access(1'b0, make_addr(0, 2, 5), 8'h00); // cold miss reads the pattern
		cpu_access(1'b1, make_addr(0, 2, 5), 8'ha7);
		cpu_access(1'b0, make_addr(0, 2, 5), 8'h00); // must hit
		for (int t = 1; t <= 4; t++) begin
			cpu_access(1'b0, make_addr(t, 2, t), 8'h00);
		end
		check("write-back count", 128'(1), 128'(writebacks)); // dirty tag 0 left
		cpu_access(1'b0, make_addr(5, 2, 0), 8'h00);
		check("write-back count", 128'(1), 128'(writebacks)); // clean victim

		repeat (2000) begin
			cpu_access(1'($urandom_range(0, 1)),
				make_addr($urandom_range(0, 5), $urandom_range(0, 7), $urandom_range(0, 15)),
				byte_t'($urandom));
		end

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top
	import cache_pkg::*;
(
	input  logic   clk,
	input  logic   reset_i,

	input  logic   cpu_req_i,
	input  logic   cpu_we_i,
	input  addr_t  cpu_addr_i,
	input  byte_t  cpu_wdata_i,
	output logic   cpu_ready_o,
	output byte_t  cpu_rdata_o,

	output logic   mem_valid_o,
	output logic   mem_we_o,
	output addr_t  mem_addr_o,
	output block_t mem_wdata_o,
	input  logic   mem_ready_i,
	input  block_t mem_rdata_i
);

	tag_t    tag;
	set_t    set;
	offset_t offset;

	logic    hit;
	way_t    hit_way;
	way_t    victim_way;
	logic    victim_dirty;
	tag_t    victim_tag;
	logic    byte_we;
	logic    fill;
	logic    touch;

	assign tag    = cpu_addr_i[31:7];
	assign set    = cpu_addr_i[6:4];
	assign offset = cpu_addr_i[3:0];

	// write-back goes to the victim block, allocate to the requested one
	assign mem_addr_o = {(mem_we_o ? victim_tag : tag), set, offset_t'(0)};

	cache_ctrl i_ctrl (
		.clk            (clk),
		.reset_i        (reset_i),
		.cpu_req_i      (cpu_req_i),
		.cpu_we_i       (cpu_we_i),
		.hit_i          (hit),
		.victim_dirty_i (victim_dirty),
		.mem_ready_i    (mem_ready_i),
		.cpu_ready_o    (cpu_ready_o),
		.byte_we_o      (byte_we),
		.fill_o         (fill),
		.touch_o        (touch),
		.mem_valid_o    (mem_valid_o),
		.mem_we_o       (mem_we_o)
	);

	lru_ages i_lru (
		.clk      (clk),
		.reset_i  (reset_i),
		.touch_i  (touch),
		.set_i    (set),
		.way_i    (hit_way),
		.victim_o (victim_way)
	);

	cache_ways i_ways (
		.clk            (clk),
		.reset_i        (reset_i),
		.set_i          (set),
		.tag_i          (tag),
		.offset_i       (offset),
		.byte_we_i      (byte_we),
		.wdata_i        (cpu_wdata_i),
		.fill_i         (fill),
		.fill_data_i    (mem_rdata_i),
		.victim_way_i   (victim_way),
		.hit_o          (hit),
		.hit_way_o      (hit_way),
		.rdata_o        (cpu_rdata_o),
		.victim_dirty_o (victim_dirty),
		.victim_tag_o   (victim_tag),
		.victim_data_o  (mem_wdata_o)
	);

endmodule

`default_nettype wire

// ==== source/cache_ways.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ways
	import cache_pkg::*;
(
	input  logic    clk,
	input  logic    reset_i,

	input  set_t    set_i,
	input  tag_t    tag_i,
	input  offset_t offset_i,

	input  logic    byte_we_i,
	input  byte_t   wdata_i,
	input  logic    fill_i,
	input  block_t  fill_data_i,
	input  way_t    victim_way_i,

	output logic    hit_o,
	output way_t    hit_way_o,
	output byte_t   rdata_o,
	output logic    victim_dirty_o,
	output tag_t    victim_tag_o,
	output block_t  victim_data_o
);

	logic [WAYS-1:0] valid_q [SETS];
	logic [WAYS-1:0] dirty_q [SETS];
	tag_t            tag_q   [SETS][WAYS];
	block_t          data_q  [SETS][WAYS];

	logic [WAYS-1:0] match;
	logic [6:0]      bit_idx; // lowest bit of the addressed byte

	assign bit_idx = {offset_i, 3'b000};

	// tag compare across all ways of the set
	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			match[w] = valid_q[set_i][w] && (tag_q[set_i][w] == tag_i);
		end
	end

	always_comb begin
		hit_way_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (match[w]) begin
				hit_way_o = way_t'(w);
			end
		end
	end

	assign hit_o   = |match;
	assign rdata_o = data_q[set_i][hit_way_o][bit_idx +: 8];

	// what leaves the cache on a write-back
	assign victim_dirty_o = valid_q[set_i][victim_way_i] && dirty_q[set_i][victim_way_i];
	assign victim_tag_o   = tag_q[set_i][victim_way_i];
	assign victim_data_o  = data_q[set_i][victim_way_i];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int s = 0; s < SETS; s++) begin
				valid_q[s] <= '0;
				dirty_q[s] <= '0;
			end
		end else if (fill_i) begin
			valid_q[set_i][victim_way_i] <= 1'b1;
			dirty_q[set_i][victim_way_i] <= 1'b0; // fresh copy of memory
		end else if (byte_we_i) begin
			dirty_q[set_i][hit_way_o] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_i) begin
			tag_q[set_i][victim_way_i]  <= tag_i;
			data_q[set_i][victim_way_i] <= fill_data_i;
		end else if (byte_we_i) begin
			data_q[set_i][hit_way_o][bit_idx +: 8] <= wdata_i; // merge one byte
		end
	end

	// a block is never resident in two ways of a set
	a_one_match: assert property (
		@(posedge clk) disable iff (reset_i)
		$onehot0(match)
	);

endmodule

`default_nettype wire

// ==== source/lru_ages.sv ====
`timescale 1ns/1ps
`default_nettype none

module lru_ages
	import cache_pkg::*;
(
	input  logic clk,
	input  logic reset_i,

	input  logic touch_i,
	input  set_t set_i,
	input  way_t way_i,

	output way_t victim_o
);

	age_t ages_q [SETS][WAYS];

	logic [WAYS-1:0] seen;     // which ages occur in one set
	logic [SETS-1:0] set_perm; // set holds each age exactly once

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					ages_q[s][w] <= age_t'(w); // way 3 starts as oldest
				end
			end
		end else if (touch_i) begin
			for (int w = 0; w < WAYS; w++) begin
				if (way_t'(w) == way_i) begin
					ages_q[set_i][w] <= '0;
				end else if (ages_q[set_i][w] < ages_q[set_i][way_i]) begin
					ages_q[set_i][w] <= ages_q[set_i][w] + 1'b1; // younger ways age
				end
			end
		end
	end

	// oldest way in the addressed set
	always_comb begin
		victim_o = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (ages_q[set_i][w] == age_t'(WAYS - 1)) begin
				victim_o = way_t'(w);
			end
		end
	end

	always_comb begin
		seen     = '0;
		set_perm = '0;
		for (int s = 0; s < SETS; s++) begin
			seen = '0;
			for (int w = 0; w < WAYS; w++) begin
				seen[ages_q[s][w]] = 1'b1;
			end
			set_perm[s] = &seen;
		end
	end

	a_age_perm: assert property (
		@(posedge clk) disable iff (reset_i)
		touch_i |=> set_perm[$past(set_i)]
	);

endmodule

`default_nettype wire

// ==== source/cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
	import cache_pkg::*;
(
	input  logic clk,
	input  logic reset_i,

	input  logic cpu_req_i,
	input  logic cpu_we_i,
	input  logic hit_i,
	input  logic victim_dirty_i,
	input  logic mem_ready_i,

	output logic cpu_ready_o,
	output logic byte_we_o,
	output logic fill_o,
	output logic touch_o,
	output logic mem_valid_o,
	output logic mem_we_o
);

	typedef enum logic [1:0] {
		LOOKUP,
		WRITE_BACK,
		ALLOCATE
	} state_t;

	state_t state_q;
	state_t state_d;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q <= LOOKUP;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d     = state_q;
		cpu_ready_o = 1'b0;
		byte_we_o   = 1'b0;
		fill_o      = 1'b0;
		touch_o     = 1'b0;
		mem_valid_o = 1'b0;
		mem_we_o    = 1'b0;

		case (state_q)
			LOOKUP: begin
				if (cpu_req_i && hit_i) begin
					cpu_ready_o = 1'b1; // hit answers in the same cycle
					touch_o     = 1'b1;
					byte_we_o   = cpu_we_i;
				end else if (cpu_req_i) begin
					// victim must go out first if it holds modified bytes
					state_d = victim_dirty_i ? WRITE_BACK : ALLOCATE;
				end
			end

			WRITE_BACK: begin
				mem_valid_o = 1'b1;
				mem_we_o    = 1'b1;
				if (mem_ready_i) begin
					state_d = ALLOCATE;
				end
			end

			ALLOCATE: begin
				mem_valid_o = 1'b1;
				fill_o      = mem_ready_i; // block lands on the ready pulse
				if (mem_ready_i) begin
					state_d = LOOKUP; // retry the lookup, which now hits
				end
			end

			default: begin
				state_d = LOOKUP;
			end
		endcase
	end

	// the core is never answered while a block transfer is open
	a_ready_vs_mem: assert property (
		@(posedge clk) disable iff (reset_i)
		!(cpu_ready_o && mem_valid_o)
	);

	// memory request is held steady until memory answers
	a_mem_hold: assert property (
		@(posedge clk) disable iff (reset_i)
		(mem_valid_o && !mem_ready_i) |=> (mem_valid_o && $stable(mem_we_o))
	);

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// cache geometry
	localparam int WAYS        = 4;
	localparam int SETS        = 8;
	localparam int BLOCK_BYTES = 16;

	// address split is tag[31:7], set[6:4], offset[3:0]
	typedef logic [31:0] addr_t;
	typedef logic [24:0] tag_t;
	typedef logic [$clog2(SETS)-1:0] set_t;
	typedef logic [$clog2(BLOCK_BYTES)-1:0] offset_t;

	typedef logic [$clog2(WAYS)-1:0] way_t;
	typedef logic [7:0] byte_t;

	// byte k of a block sits at bits 8k+7 down to 8k
	typedef logic [BLOCK_BYTES*8-1:0] block_t;

	typedef logic [1:0] age_t; // 0 is most recent, 3 is the victim

endpackage

`default_nettype wire
